// File: source/csr_mgr.sv
// CSR manager that decodes MMIO writes and answers MMIO reads over the CSR map

`timescale 1ns/10ps

module csr_mgr
(
    input  logic                                       clk,
    input  logic                                       reset_n,

    input  logic                                       mmio_write,
    input  logic                                       mmio_read,
    input  logic [intr_test_pkg::MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  intr_test_pkg::csr_data_t                   mmio_writedata,
    output logic                                       mmio_readdatavalid,
    output intr_test_pkg::csr_data_t                   mmio_readdata,

    engine_csr_if.mgr                                  eng
);

    import intr_test_pkg::*;

    // ====================
    // Write path
    // ====================

    // Writes are registered once before they reach the engine
    // The strobe is control state and is cleared by reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            eng.wr_req <= 1'b0;
        end
        else
        begin
            eng.wr_req <= mmio_write;
        end
    end

    // Index and data only mean something while wr_req is high
    always_ff @(posedge clk)
    begin
        if (mmio_write)
        begin
            eng.wr_idx <= csr_idx_e'(mmio_address);
            eng.wr_data <= mmio_writedata;
        end
    end

    // ====================
    // Read map
    // ====================

    // Every decoded word is listed here, unused words read as zero
    csr_data_t csr_rd [NUM_CSRS];

    always_comb
    begin
        for (int i = 0; i < NUM_CSRS; i++)
        begin
            csr_rd[i] = '0;
        end

        // Test identifier split over two words, low half first
        csr_rd[CSR_TEST_ID_LO] = TEST_ID[63:0];
        csr_rd[CSR_TEST_ID_HI] = TEST_ID[127:64];

        // Number of interrupt IDs above the engine count
        // Only a single engine exists, so the count is a constant 1
        csr_rd[CSR_CONFIG][15:8] = 8'(NUM_INTR_IDS);
        csr_rd[CSR_CONFIG][7:0] = 8'd1;

        // Response count and mask come straight from the engine
        csr_rd[CSR_STATUS] = eng.status_data;
    end

    // ====================
    // Read response
    // ====================

    // Data is returned exactly one cycle after the read is sampled
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mmio_readdatavalid <= 1'b0;
        end
        else
        begin
            mmio_readdatavalid <= mmio_read;
        end
    end

    // The data word needs no reset, it is qualified by readdatavalid
    always_ff @(posedge clk)
    begin
        if (mmio_read)
        begin
            mmio_readdata <= csr_rd[mmio_address];
        end
    end

    // ====================
    // Checks
    // ====================

    // Reads and writes share one address bus, so they may not overlap
    assert property (
        @(posedge clk) disable iff (!reset_n)
        !(mmio_read && mmio_write)
    )
    else
    begin
        $error("MMIO read and write in the same cycle");
    end

endmodule

// File: source/engine_csr_if.sv
// CSR link that carries write strobes to the interrupt engine and status back

`timescale 1ns/10ps

interface engine_csr_if;

    import intr_test_pkg::*;

    // Registered copy of an MMIO write, valid for one cycle
    logic      wr_req;
    csr_idx_e  wr_idx;
    csr_data_t wr_data;

    // Engine status as it appears in CSR_STATUS
    // Mask of answered IDs in bits 11:8, response count in bits 2:0
    csr_data_t status_data;

    // High while interrupt requests are still being issued
    logic      status_active;

    // Side of the CSR manager
    modport mgr
    (
        output wr_req,
        output wr_idx,
        output wr_data,
        input  status_data,
        input  status_active
    );

    // Side of the interrupt engine
    modport engine
    (
        input  wr_req,
        input  wr_idx,
        input  wr_data,
        output status_data,
        output status_active
    );

endinterface

// File: source/intr_engine.sv
// Interrupt engine that sends one interrupt per ID and records the responses

`timescale 1ns/10ps

module intr_engine
(
    input  logic                                       clk,
    input  logic                                       reset_n,

    engine_csr_if.engine                               csr,

    output logic                                       host_wr_write,
    output logic [intr_test_pkg::HOST_ADDR_WIDTH-1:0] host_wr_address,
    output intr_test_pkg::host_user_t                  host_wr_user,
    input  logic                                       host_waitrequest,
    input  logic                                       host_wr_response_valid,
    input  intr_test_pkg::host_user_t                  host_wr_response_user
);

    import intr_test_pkg::*;

    eng_state_e  state;
    intr_id_t    cur_id;
    intr_id_t    max_id;

    intr_count_t rsp_count;
    logic [NUM_INTR_IDS-1:0] rsp_mask;

    logic        start_cmd;
    logic        req_accepted;
    logic        rsp_flagged;
    intr_id_t    rsp_id;

    // A write to CSR 0 starts a run, even while one is already going
    assign start_cmd = csr.wr_req && (csr.wr_idx == CSR_TEST_ID_LO);

    // The host takes a request on any edge where it is not waiting
    assign req_accepted = (state == ENG_ISSUE) && !host_waitrequest;

    // ====================
    // Request sequencer
    // ====================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ENG_IDLE;
            cur_id <= '0;
        end
        else if (start_cmd)
        begin
            // Restart from ID 0 whatever the current state is
            state <= ENG_ISSUE;
            cur_id <= '0;
        end
        else if (req_accepted)
        begin
            // Leave once the highest ID has been taken by the host
            if (cur_id == max_id)
            begin
                state <= ENG_IDLE;
            end
            cur_id <= cur_id + 1'b1;
        end
    end

    // Highest ID comes from the low bits of the start write
    always_ff @(posedge clk)
    begin
        if (start_cmd)
        begin
            max_id <= csr.wr_data[INTR_ID_WIDTH-1:0];
        end
    end

    // The request is a level that follows the state
    // It is held low during reset, before the state register settles
    assign host_wr_write = (state == ENG_ISSUE) && reset_n;
    assign host_wr_address = HOST_ADDR_WIDTH'(cur_id);

    // Flag the write as an interrupt and carry the ID so a response can be matched
    always_comb
    begin
        host_wr_user = '0;
        host_wr_user[UFLAG_INTERRUPT] = 1'b1;
        host_wr_user[UFLAG_ID_LSB +: INTR_ID_WIDTH] = cur_id;
    end

    // ====================
    // Response tracking
    // ====================

    assign rsp_flagged = host_wr_response_valid && host_wr_response_user[UFLAG_INTERRUPT];
    assign rsp_id = host_wr_response_user[UFLAG_ID_LSB +: INTR_ID_WIDTH];

    always_ff @(posedge clk)
    begin
        if (!reset_n || start_cmd)
        begin
            rsp_count <= '0;
            rsp_mask <= '0;
        end
        else if (rsp_flagged)
        begin
            rsp_count <= rsp_count + 1'b1;
            rsp_mask[rsp_id] <= 1'b1;
        end
    end

    // Status word as software sees it in CSR_STATUS
    always_comb
    begin
        csr.status_data = '0;
        csr.status_data[11:8] = rsp_mask;
        csr.status_data[2:0] = rsp_count;
    end

    assign csr.status_active = (state == ENG_ISSUE);

    // ====================
    // Checks
    // ====================

    // Every write response from the host must be an interrupt answer without fence
    assert property (
        @(posedge clk) disable iff (!reset_n)
        host_wr_response_valid |->
            (host_wr_response_user[UFLAG_INTERRUPT] && !host_wr_response_user[UFLAG_FENCE])
    )
    else
    begin
        $error("Response user flags wrong: %h", host_wr_response_user);
    end

    // A request the host is holding off stays unchanged, unless software restarts
    assert property (
        @(posedge clk) disable iff (!reset_n)
        (host_wr_write && host_waitrequest && !start_cmd) |=>
            (host_wr_write && $stable(host_wr_address) && $stable(host_wr_user))
    )
    else
    begin
        $error("Waiting interrupt request changed");
    end

endmodule

// File: source/intr_test_afu.sv
// Top level of the host-interrupt test block with MMIO and host-channel ports

`timescale 1ns/10ps

module intr_test_afu
(
    input  logic                                       clk,
    input  logic                                       reset_n,

    // MMIO from software, one 64-bit CSR word per address
    input  logic                                       mmio_write,
    input  logic                                       mmio_read,
    input  logic [intr_test_pkg::MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  intr_test_pkg::csr_data_t                   mmio_writedata,
    output logic                                       mmio_readdatavalid,
    output intr_test_pkg::csr_data_t                   mmio_readdata,

    // Host write channel that carries the interrupt requests
    output logic                                       host_wr_write,
    output logic [intr_test_pkg::HOST_ADDR_WIDTH-1:0] host_wr_address,
    output intr_test_pkg::host_user_t                  host_wr_user,
    input  logic                                       host_waitrequest,
    input  logic                                       host_wr_response_valid,
    input  intr_test_pkg::host_user_t                  host_wr_response_user
);

    // Write strobes go down, status comes back up
    engine_csr_if eng_csr ();

    csr_mgr u_csr_mgr
    (
        .clk                    (clk),
        .reset_n                (reset_n),
        .mmio_write             (mmio_write),
        .mmio_read              (mmio_read),
        .mmio_address           (mmio_address),
        .mmio_writedata         (mmio_writedata),
        .mmio_readdatavalid     (mmio_readdatavalid),
        .mmio_readdata          (mmio_readdata),
        .eng                    (eng_csr)
    );

    // Single engine, started through CSR 0
    intr_engine u_intr_engine
    (
        .clk                    (clk),
        .reset_n                (reset_n),
        .csr                    (eng_csr),
        .host_wr_write          (host_wr_write),
        .host_wr_address        (host_wr_address),
        .host_wr_user           (host_wr_user),
        .host_waitrequest       (host_waitrequest),
        .host_wr_response_valid (host_wr_response_valid),
        .host_wr_response_user  (host_wr_response_user)
    );

endmodule

// File: source/intr_test_pkg.sv
// Shared widths, types and constants for the host-interrupt test block

package intr_test_pkg;

    // ====================
    // Interrupt IDs
    // ====================

    // One request is sent per ID, counting up from 0
    localparam int NUM_INTR_IDS = 4;
    localparam int INTR_ID_WIDTH = 2;

    typedef logic [INTR_ID_WIDTH-1:0] intr_id_t;

    // Must hold every value from 0 up to NUM_INTR_IDS
    typedef logic [2:0] intr_count_t;

    // ====================
    // CSR space
    // ====================

    // MMIO addresses are 64-bit word indices
    localparam int MMIO_ADDR_WIDTH = 4;
    localparam int NUM_CSRS = 16;

    typedef logic [63:0] csr_data_t;

    typedef enum logic [MMIO_ADDR_WIDTH-1:0] {
        CSR_TEST_ID_LO = 0,
        CSR_TEST_ID_HI = 1,
        CSR_CONFIG = 2,
        CSR_STATUS = 3
    } csr_idx_e;

    // Identifies this test to the driver, read back as two words
    localparam logic [127:0] TEST_ID = 128'h5b1e_0c47_9a2d_4e83_b6f1_07c3_d29a_6e45;

    // ====================
    // Host channel
    // ====================

    localparam int HOST_ADDR_WIDTH = 16;

    typedef logic [7:0] host_user_t;

    // Bit positions inside the user field of requests and responses
    localparam int UFLAG_INTERRUPT = 0;
    localparam int UFLAG_FENCE = 1;
    localparam int UFLAG_ID_LSB = 2;

    typedef enum logic {
        ENG_IDLE,
        ENG_ISSUE
    } eng_state_e;

endpackage

// File: tb.f
source/intr_test_pkg.sv
source/engine_csr_if.sv
source/csr_mgr.sv
source/intr_engine.sv
source/intr_test_afu.sv
tests/host_intr_responder.sv
tests/tb_intr_test.sv

// File: tests/host_intr_responder.sv
// Host channel model that holds off interrupt requests at random and answers them in order

`timescale 1ns/10ps

module host_intr_responder
(
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       host_wr_write,
    input  logic [intr_test_pkg::HOST_ADDR_WIDTH-1:0] host_wr_address,
    input  intr_test_pkg::host_user_t                  host_wr_user,
    output logic                                       host_waitrequest,
    output logic                                       host_wr_response_valid,
    output intr_test_pkg::host_user_t                  host_wr_response_user
);

    import intr_test_pkg::*;

    logic [31:0] lfsr;
    intr_id_t    pend_q[$];
    host_user_t  log_q[$];
    logic [HOST_ADDR_WIDTH-1:0] addr_log_q[$];
    int          wait_left;
    int          rsp_delay;
    logic        redraw_wait;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // The LFSR moves one step for every bit that is drawn
    function int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | lfsr[0];
        end
        return val;
    endfunction

    initial
    begin
        lfsr = 32'h95ae8161;
        wait_left = 0;
        rsp_delay = 0;
        redraw_wait = 1'b1;
        host_waitrequest = 1'b1;
        host_wr_response_valid = 1'b0;
        host_wr_response_user = '0;
    end

    // A request counts as taken on the same rising edge where the DUT sees it taken
    // The whole user field and the address are logged for the checks
    always @(posedge clk)
    begin
        if (!reset_n)
            pend_q.delete();
        else if (host_wr_write && !host_waitrequest)
        begin
            pend_q.push_back(host_wr_user[UFLAG_ID_LSB +: INTR_ID_WIDTH]);
            log_q.push_back(host_wr_user);
            addr_log_q.push_back(host_wr_address);
            redraw_wait = 1'b1;
        end
    end

    // Wait cycles and response gaps of 0 to 3 cycles, driven on the falling edge
    always @(negedge clk)
    begin
        if (redraw_wait)
        begin
            wait_left = rand_bits(2);
            redraw_wait = 1'b0;
        end
        host_waitrequest = (wait_left != 0);
        if (wait_left != 0)
            wait_left--;

        host_wr_response_valid = 1'b0;
        if (rsp_delay != 0)
            rsp_delay--;
        else if (reset_n && pend_q.size() != 0)
        begin
            // Echo the ID with the interrupt flag, fence flag left clear
            host_wr_response_valid = 1'b1;
            host_wr_response_user = '0;
            host_wr_response_user[UFLAG_INTERRUPT] = 1'b1;
            host_wr_response_user[UFLAG_ID_LSB +: INTR_ID_WIDTH] = pend_q.pop_front();
            rsp_delay = rand_bits(2);
        end
    end

endmodule

// File: tests/tb_intr_test.sv
// Directed testbench for the host-interrupt test block

`timescale 1ns/10ps

module tb_intr_test;

    import intr_test_pkg::*;

    logic clk, reset_n;
    logic mmio_write, mmio_read, mmio_readdatavalid;
    logic [MMIO_ADDR_WIDTH-1:0] mmio_address;
    csr_data_t mmio_writedata, mmio_readdata;
    logic host_wr_write, host_waitrequest, host_wr_response_valid;
    logic [HOST_ADDR_WIDTH-1:0] host_wr_address;
    host_user_t host_wr_user, host_wr_response_user;
    int test_errs, err_total, tests_failed, tests_run;

    intr_test_afu u_dut (.*);
    host_intr_responder u_resp (.*);

    always #4 clk = ~clk;

    // ====================
    // Bus helpers
    // ====================

    task automatic abort_run(input string why);
        $display("Timed out waiting for %s", why);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic check_value(input string what, input csr_data_t got, input csr_data_t exp);
        assert (got === exp)
        else
        begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic write_csr(input logic [MMIO_ADDR_WIDTH-1:0] idx, input csr_data_t data);
        mmio_address = idx;
        mmio_writedata = data;
        mmio_write = 1'b1;
        @(negedge clk);
        mmio_write = 1'b0;
    endtask

    // Read data is due exactly one cycle after the read is sampled
    task automatic read_expect(input logic [MMIO_ADDR_WIDTH-1:0] idx, input csr_data_t exp,
                               input string what);
        mmio_address = idx;
        mmio_read = 1'b1;
        @(negedge clk);
        mmio_read = 1'b0;
        check_value({what, " valid"}, 64'(mmio_readdatavalid), 64'd1);
        check_value(what, mmio_readdata, exp);
    endtask

    task automatic wait_request_level(input logic level);
        int cycles;
        cycles = 0;
        while (host_wr_write !== level && cycles < 200)
        begin
            @(negedge clk);
            cycles++;
        end
        if (host_wr_write !== level)
            abort_run("the interrupt request level");
    endtask

    // A run is over once the engine drops its active status
    task automatic wait_run_end();
        int cycles;
        cycles = 0;
        while (u_dut.eng_csr.status_active !== 1'b0 && cycles < 200)
        begin
            @(negedge clk);
            cycles++;
        end
        if (u_dut.eng_csr.status_active !== 1'b0)
            abort_run("the end of the interrupt run");
    endtask

    task automatic report_test(input string name);
        tests_run++;
        err_total += test_errs;
        tests_failed += (test_errs != 0);
        $display("%s: %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    // ====================
    // Tests
    // ====================

    task automatic test_ident();
        read_expect(CSR_TEST_ID_LO, TEST_ID[63:0], "TEST_ID low");
        read_expect(CSR_TEST_ID_HI, TEST_ID[127:64], "TEST_ID high");
        // Four interrupt IDs in bits 15:8 and one engine in bits 7:0
        read_expect(CSR_CONFIG, 64'h0401, "CONFIG");
        read_expect(4'd5, 64'd0, "CSR 5");
        report_test("identification");
    endtask

    // IDs go out from 0 up to the highest ID and each one is answered once
    task automatic test_run(input int max_id, input string name);
        int base;
        int cycles;
        base = u_resp.log_q.size();
        write_csr(CSR_TEST_ID_LO, 64'(max_id));
        wait_request_level(1'b1);
        wait_run_end();
        // Responses leave the host queue on the falling edge, so look on the rising edge
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (u_resp.pend_q.size() != 0 && cycles < 200);
        if (u_resp.pend_q.size() != 0)
            abort_run("interrupt responses");
        @(negedge clk);
        check_value("request count", u_resp.log_q.size() - base, max_id + 1);
        for (int i = 0; i <= max_id && base + i < u_resp.log_q.size(); i++)
        begin
            // Interrupt flag set, fence flag clear and the ID in the user field
            check_value("request user", u_resp.log_q[base + i],
                        (i << UFLAG_ID_LSB) | (1 << UFLAG_INTERRUPT));
            check_value("request address", u_resp.addr_log_q[base + i], i);
        end
        // Mask of answered IDs in bits 11:8 and the count in bits 2:0
        read_expect(CSR_STATUS, {52'd0, 4'((1 << (max_id + 1)) - 1), 5'd0, 3'(max_id + 1)},
                    "status");
        report_test(name);
    endtask

    // Reset in the middle of a run drops the request and clears the status
    task automatic test_reset_mid();
        int base;
        int cycles;
        int high_cycles;
        high_cycles = 0;
        write_csr(CSR_TEST_ID_LO, 64'(NUM_INTR_IDS - 1));
        wait_request_level(1'b1);
        // Let the engine count a first response, so the status has something to clear
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
        end
        while (host_wr_response_valid !== 1'b1 && cycles < 200);
        if (host_wr_response_valid !== 1'b1)
            abort_run("a first interrupt response");
        @(negedge clk);
        reset_n = 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            high_cycles += host_wr_write;
        end
        reset_n = 1'b1;
        base = u_resp.log_q.size();
        // Longer than a full run with the most back-pressure the host model gives
        repeat (24)
        begin
            @(negedge clk);
            high_cycles += host_wr_write;
        end
        check_value("requests in and after reset", high_cycles + u_resp.log_q.size() - base, 0);
        read_expect(CSR_STATUS, 64'd0, "status after reset");
        report_test("reset mid-run");
    endtask

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        mmio_write = 1'b0;
        mmio_read = 1'b0;
        mmio_address = '0;
        mmio_writedata = '0;
        test_errs = 0;
        err_total = 0;
        tests_failed = 0;
        tests_run = 0;
        // Reset is seen on three rising edges
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        test_ident();
        test_run(0, "single interrupt");
        test_run(NUM_INTR_IDS - 1, "full run");
        // A new start right after the full run must clear its count and mask
        test_run(1, "restart");
        test_reset_mid();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_total);
        if (err_total == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
